/* hw/ccu_defines.svh */
`ifndef CCU_DEFINES_SVH
`define CCU_DEFINES_SVH

// caching masters on the interconnect
`define CCU_NUM_MASTERS 4

// bus widths
`define CCU_ADDR_W      32
`define CCU_DATA_W      64

// per-master transaction id, master index sits above it
`define CCU_SLV_ID_W    2

// one cache line is two data beats
`define CCU_LINE_BEATS  2

// ACE snoop code on ar and ac
`define CCU_SNOOP_W     4

`endif

/* hw/ccu_pkg.sv */
`include "ccu_defines.svh"

package ccu_pkg;

    typedef logic [`CCU_ADDR_W-1:0] addr_t;
    typedef logic [`CCU_DATA_W-1:0] data_t;

    // index of a caching master
    typedef logic [$clog2(`CCU_NUM_MASTERS)-1:0] mst_idx_t;

    // full id as seen by the CCU, {master index, slave id}
    typedef logic [`CCU_SLV_ID_W+$clog2(`CCU_NUM_MASTERS)-1:0] id_t;

    // one bit per master
    typedef logic [`CCU_NUM_MASTERS-1:0] mst_vec_t;

    typedef logic [`CCU_SNOOP_W-1:0] snoop_t;

    // read path controller
    typedef enum logic [2:0] {
        IDLE,
        SNOOP_REQ,
        SNOOP_RESP,
        SNOOP_DATA,
        MEM_AR,
        MEM_READ
    } ccu_state_e;

endpackage

/* hw/ccu_req_capture.sv */
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_req_capture
    import ccu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  ccu_state_e state_i,
    input  logic       ar_valid_i,
    input  addr_t      ar_addr_i,
    input  id_t        ar_id_i,
    input  snoop_t     ar_snoop_i,
    output logic       ar_ready_o,
    output addr_t      req_addr_o,
    output id_t        req_id_o,
    output snoop_t     req_snoop_o,
    output mst_vec_t   initiator_o
);

    // byte offset bits within one cache line
    localparam int unsigned LineOffW = $clog2(`CCU_LINE_BEATS * `CCU_DATA_W / 8);

    logic     ar_hs;
    addr_t    line_addr;
    mst_idx_t init_idx;
    mst_vec_t init_dec;

    addr_t    req_addr_q;
    id_t      req_id_q;
    snoop_t   req_snoop_q;
    mst_vec_t initiator_q;

    // one request in flight, accept only when idle
    assign ar_ready_o = (state_i == IDLE);
    assign ar_hs      = ar_valid_i & ar_ready_o;

    // master index lives above the slave id bits
    assign init_idx = ar_id_i[`CCU_SLV_ID_W +: $bits(mst_idx_t)];

    always_comb begin
        init_dec = '0;
        init_dec[init_idx] = 1'b1;
        line_addr = ar_addr_i;
        line_addr[LineOffW-1:0] = '0;
    end

    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            req_addr_q  <= line_addr;
            req_id_q    <= ar_id_i;
            req_snoop_q <= ar_snoop_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            initiator_q <= '0;
        end else if (ar_hs) begin
            initiator_q <= init_dec;
        end
    end

    assign req_addr_o  = req_addr_q;
    assign req_id_o    = req_id_q;
    assign req_snoop_o = req_snoop_q;
    assign initiator_o = initiator_q;

endmodule

/* hw/ccu_snoop_collect.sv */
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_snoop_collect
    import ccu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  ccu_state_e state_i,
    input  mst_vec_t   initiator_i,
    input  addr_t      req_addr_i,
    input  snoop_t     req_snoop_i,
    output mst_vec_t   ac_valid_o,
    input  mst_vec_t   ac_ready_i,
    output addr_t      ac_addr_o,
    output snoop_t     ac_snoop_o,
    input  mst_vec_t   cr_valid_i,
    output mst_vec_t   cr_ready_o,
    input  mst_vec_t   cr_data_transfer_i,
    input  mst_vec_t   cr_error_i,
    input  mst_vec_t   cr_shared_i,
    input  mst_vec_t   cr_dirty_i,
    output logic       ac_done_o,
    output logic       all_resp_o,
    output logic       hit_o,
    output mst_idx_t   responder_o,
    output mst_vec_t   data_avail_o,
    output logic       shared_any_o,
    output logic       dirty_any_o
);

    mst_vec_t ac_taken_q;
    mst_vec_t resp_q;
    mst_vec_t data_q;
    mst_vec_t err_q;
    mst_vec_t shared_q;
    mst_vec_t dirty_q;
    mst_vec_t ac_hs;
    mst_vec_t cr_hs;
    mst_vec_t good;

    // --------------------------------------------------
    // snoop address channel
    // --------------------------------------------------
    // address and snoop code are common, the initiator is skipped
    assign ac_addr_o  = req_addr_i;
    assign ac_snoop_o = req_snoop_i;
    assign ac_valid_o = (state_i == SNOOP_REQ) ? ~(ac_taken_q | initiator_i) : '0;
    assign ac_hs      = ac_valid_o & ac_ready_i;
    assign ac_done_o  = (state_i == SNOOP_REQ) && (&(ac_taken_q | initiator_i | ac_hs));

    // --------------------------------------------------
    // snoop response channel
    // --------------------------------------------------
    assign cr_ready_o = (state_i == SNOOP_RESP) ? ~resp_q : '0;
    assign cr_hs      = cr_valid_i & cr_ready_o;
    assign all_resp_o = (state_i == SNOOP_RESP) && (&resp_q);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ac_taken_q <= '0;
            resp_q     <= '0;
            data_q     <= '0;
            err_q      <= '0;
            shared_q   <= '0;
            dirty_q    <= '0;
        end else if (state_i == IDLE) begin
            ac_taken_q <= '0;
            resp_q     <= '0;
            data_q     <= '0;
            err_q      <= '0;
            shared_q   <= '0;
            dirty_q    <= '0;
        end else if (state_i == SNOOP_REQ) begin
            ac_taken_q <= ac_taken_q | ac_hs;
            // initiator counts as already responded
            resp_q     <= initiator_i;
        end else begin
            resp_q   <= resp_q | cr_hs;
            data_q   <= (data_q & ~cr_hs) | (cr_data_transfer_i & cr_hs);
            err_q    <= (err_q & ~cr_hs) | (cr_error_i & cr_hs);
            shared_q <= (shared_q & ~cr_hs) | (cr_shared_i & cr_hs);
            dirty_q  <= (dirty_q & ~cr_hs) | (cr_dirty_i & cr_hs);
        end
    end

    // error-free data holders, lowest index wins
    assign good = data_q & ~err_q;
    assign hit_o = |good;

    always_comb begin
        responder_o = '0;
        for (int i = `CCU_NUM_MASTERS - 1; i >= 0; i--) begin
            if (good[i]) begin
                responder_o = mst_idx_t'(i);
            end
        end
    end

    assign data_avail_o = data_q;
    assign shared_any_o = |shared_q;
    assign dirty_any_o  = |dirty_q;

endmodule

/* hw/ccu_ctrl_fsm.sv */
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_ctrl_fsm
    import ccu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       ar_valid_i,
    input  logic       ar_ready_i,
    input  logic       ac_done_i,
    input  logic       all_resp_i,
    input  logic       hit_i,
    input  logic       line_done_i,
    input  addr_t      req_addr_i,
    input  id_t        req_id_i,
    output logic       mem_ar_valid_o,
    input  logic       mem_ar_ready_i,
    output addr_t      mem_ar_addr_o,
    output id_t        mem_ar_id_o,
    output ccu_state_e state_o
);

    ccu_state_e state_d;
    ccu_state_e state_q;

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ar_valid_i && ar_ready_i) begin
                    state_d = SNOOP_REQ;
                end
            end
            SNOOP_REQ: begin
                // every other master took its snoop
                if (ac_done_i) begin
                    state_d = SNOOP_RESP;
                end
            end
            SNOOP_RESP: begin
                if (all_resp_i) begin
                    state_d = hit_i ? SNOOP_DATA : MEM_AR;
                end
            end
            SNOOP_DATA: begin
                if (line_done_i) begin
                    state_d = IDLE;
                end
            end
            MEM_AR: begin
                if (mem_ar_ready_i) begin
                    state_d = MEM_READ;
                end
            end
            MEM_READ: begin
                if (line_done_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // memory read of the whole line on a snoop miss
    assign mem_ar_valid_o = (state_q == MEM_AR);
    assign mem_ar_addr_o  = req_addr_i;
    assign mem_ar_id_o    = req_id_i;

    assign state_o = state_q;

endmodule

/* hw/ccu_read_return.sv */
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_read_return
    import ccu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  ccu_state_e state_i,
    input  id_t        req_id_i,
    input  mst_idx_t   responder_i,
    input  mst_vec_t   data_avail_i,
    input  logic       shared_any_i,
    input  logic       dirty_any_i,
    input  mst_vec_t   cd_valid_i,
    output mst_vec_t   cd_ready_o,
    input  data_t [`CCU_NUM_MASTERS-1:0] cd_data_i,
    input  mst_vec_t   cd_last_i,
    input  logic       mem_r_valid_i,
    output logic       mem_r_ready_o,
    input  data_t      mem_r_data_i,
    input  logic       mem_r_last_i,
    output logic       r_valid_o,
    input  logic       r_ready_i,
    output data_t      r_data_o,
    output id_t        r_id_o,
    output logic       r_last_o,
    output logic       r_shared_o,
    output logic       r_dirty_o,
    output logic       line_done_o
);

    localparam int unsigned IdxW = $clog2(`CCU_LINE_BEATS);
    localparam int unsigned CntW = $clog2(`CCU_LINE_BEATS + 1);

    data_t           line_q [`CCU_LINE_BEATS];
    logic [IdxW-1:0] sent_q;
    logic [CntW-1:0] stored_q;
    logic [IdxW-1:0] wr_idx;
    mst_vec_t        cd_last_q;
    mst_vec_t        cd_hs;
    logic            drain;
    logic            resp_hs;
    logic            r_hs;

    // --------------------------------------------------
    // snoop data intake
    // --------------------------------------------------
    // every data master is drained, also on the memory path
    assign drain = (state_i == SNOOP_DATA) || (state_i == MEM_AR) || (state_i == MEM_READ);
    assign cd_ready_o = drain ? (data_avail_i & ~cd_last_q) : '0;
    assign cd_hs = cd_valid_i & cd_ready_o;

    // only the responder's beats land in the line buffer
    assign resp_hs = (state_i == SNOOP_DATA) && cd_hs[responder_i];
    // beats received so far give the slot
    assign wr_idx = IdxW'(sent_q + stored_q);

    always_ff @(posedge clk_i) begin
        if (resp_hs) begin
            line_q[wr_idx] <= cd_data_i[responder_i];
        end
    end

    // --------------------------------------------------
    // read data channel
    // --------------------------------------------------
    always_comb begin
        r_valid_o     = 1'b0;
        r_data_o      = line_q[sent_q];
        r_last_o      = (sent_q == IdxW'(`CCU_LINE_BEATS - 1));
        r_shared_o    = 1'b0;
        r_dirty_o     = 1'b0;
        mem_r_ready_o = 1'b0;
        case (state_i)
            SNOOP_DATA: begin
                r_valid_o  = (stored_q != '0);
                r_shared_o = shared_any_i;
                r_dirty_o  = dirty_any_i;
            end
            MEM_READ: begin
                // straight pass-through from memory
                r_valid_o     = mem_r_valid_i;
                r_data_o      = mem_r_data_i;
                r_last_o      = mem_r_last_i;
                mem_r_ready_o = r_ready_i;
            end
            default: begin
            end
        endcase
    end

    assign r_id_o      = req_id_i;
    assign r_hs        = r_valid_o & r_ready_i;
    assign line_done_o = r_hs & r_last_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sent_q    <= '0;
            stored_q  <= '0;
            cd_last_q <= '0;
        end else if (state_i == IDLE) begin
            sent_q    <= '0;
            stored_q  <= '0;
            cd_last_q <= '0;
        end else begin
            cd_last_q <= cd_last_q | (cd_hs & cd_last_i);
            if (state_i == SNOOP_DATA) begin
                if (r_hs) begin
                    sent_q <= sent_q + 1'b1;
                end
                // beats stored but not yet sent
                if (resp_hs && !r_hs) begin
                    stored_q <= stored_q + CntW'(1);
                end else if (r_hs && !resp_hs) begin
                    stored_q <= stored_q - CntW'(1);
                end
            end
        end
    end

endmodule

/* hw/ccu_top.sv */
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_top
    import ccu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    // read request and data to the masters
    input  logic     ar_valid_i,
    output logic     ar_ready_o,
    input  addr_t    ar_addr_i,
    input  id_t      ar_id_i,
    input  snoop_t   ar_snoop_i,
    output logic     r_valid_o,
    input  logic     r_ready_i,
    output data_t    r_data_o,
    output id_t      r_id_o,
    output logic     r_last_o,
    output logic     r_shared_o,
    output logic     r_dirty_o,
    // memory side
    output logic     mem_ar_valid_o,
    input  logic     mem_ar_ready_i,
    output addr_t    mem_ar_addr_o,
    output id_t      mem_ar_id_o,
    input  logic     mem_r_valid_i,
    output logic     mem_r_ready_o,
    input  data_t    mem_r_data_i,
    input  logic     mem_r_last_i,
    // snoop channels
    output mst_vec_t ac_valid_o,
    input  mst_vec_t ac_ready_i,
    output addr_t    ac_addr_o,
    output snoop_t   ac_snoop_o,
    input  mst_vec_t cr_valid_i,
    output mst_vec_t cr_ready_o,
    input  mst_vec_t cr_data_transfer_i,
    input  mst_vec_t cr_error_i,
    input  mst_vec_t cr_shared_i,
    input  mst_vec_t cr_dirty_i,
    input  mst_vec_t cd_valid_i,
    output mst_vec_t cd_ready_o,
    input  data_t [`CCU_NUM_MASTERS-1:0] cd_data_i,
    input  mst_vec_t cd_last_i
);

    ccu_state_e state_q;
    addr_t      req_addr;
    id_t        req_id;
    snoop_t     req_snoop;
    mst_vec_t   initiator;
    logic       ac_done;
    logic       all_resp;
    logic       hit;
    mst_idx_t   responder;
    mst_vec_t   data_avail;
    logic       shared_any;
    logic       dirty_any;
    logic       line_done;

    ccu_req_capture i_req_capture (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .state_i     (state_q),
        .ar_valid_i  (ar_valid_i),
        .ar_addr_i   (ar_addr_i),
        .ar_id_i     (ar_id_i),
        .ar_snoop_i  (ar_snoop_i),
        .ar_ready_o  (ar_ready_o),
        .req_addr_o  (req_addr),
        .req_id_o    (req_id),
        .req_snoop_o (req_snoop),
        .initiator_o (initiator)
    );

    ccu_snoop_collect i_snoop_collect (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .state_i            (state_q),
        .initiator_i        (initiator),
        .req_addr_i         (req_addr),
        .req_snoop_i        (req_snoop),
        .ac_valid_o         (ac_valid_o),
        .ac_ready_i         (ac_ready_i),
        .ac_addr_o          (ac_addr_o),
        .ac_snoop_o         (ac_snoop_o),
        .cr_valid_i         (cr_valid_i),
        .cr_ready_o         (cr_ready_o),
        .cr_data_transfer_i (cr_data_transfer_i),
        .cr_error_i         (cr_error_i),
        .cr_shared_i        (cr_shared_i),
        .cr_dirty_i         (cr_dirty_i),
        .ac_done_o          (ac_done),
        .all_resp_o         (all_resp),
        .hit_o              (hit),
        .responder_o        (responder),
        .data_avail_o       (data_avail),
        .shared_any_o       (shared_any),
        .dirty_any_o        (dirty_any)
    );

    ccu_ctrl_fsm i_ctrl_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ar_valid_i     (ar_valid_i),
        .ar_ready_i     (ar_ready_o),
        .ac_done_i      (ac_done),
        .all_resp_i     (all_resp),
        .hit_i          (hit),
        .line_done_i    (line_done),
        .req_addr_i     (req_addr),
        .req_id_i       (req_id),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_ar_addr_o  (mem_ar_addr_o),
        .mem_ar_id_o    (mem_ar_id_o),
        .state_o        (state_q)
    );

    ccu_read_return i_read_return (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .state_i       (state_q),
        .req_id_i      (req_id),
        .responder_i   (responder),
        .data_avail_i  (data_avail),
        .shared_any_i  (shared_any),
        .dirty_any_i   (dirty_any),
        .cd_valid_i    (cd_valid_i),
        .cd_ready_o    (cd_ready_o),
        .cd_data_i     (cd_data_i),
        .cd_last_i     (cd_last_i),
        .mem_r_valid_i (mem_r_valid_i),
        .mem_r_ready_o (mem_r_ready_o),
        .mem_r_data_i  (mem_r_data_i),
        .mem_r_last_i  (mem_r_last_i),
        .r_valid_o     (r_valid_o),
        .r_ready_i     (r_ready_i),
        .r_data_o      (r_data_o),
        .r_id_o        (r_id_o),
        .r_last_o      (r_last_o),
        .r_shared_o    (r_shared_o),
        .r_dirty_o     (r_dirty_o),
        .line_done_o   (line_done)
    );

endmodule

/* testbench/ccu_asserts.sv */
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_asserts
    import ccu_pkg::*;
(
    input logic     clk_i,
    input logic     rst_ni,
    input logic     ar_valid_i,
    input logic     ar_ready_i,
    input id_t      ar_id_i,
    input logic     r_valid_i,
    input logic     r_ready_i,
    input data_t    r_data_i,
    input logic     r_last_i,
    input logic     r_shared_i,
    input logic     r_dirty_i,
    input logic     mem_ar_valid_i,
    input mst_vec_t ac_valid_i,
    input mst_vec_t cr_ready_i
);

    // count of failed assertions
    int unsigned fail_cnt;
    mst_idx_t    init_idx_q;

    initial begin
        fail_cnt = 0;
    end

    // initiating master of the request in flight, from the ar id
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_idx_q <= '0;
        end else if (ar_valid_i && ar_ready_i) begin
            init_idx_q <= ar_id_i[`CCU_SLV_ID_W +: $bits(mst_idx_t)];
        end
    end

    // stalled read beat holds its payload
    r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_last_i)
            && $stable(r_shared_i) && $stable(r_dirty_i))
    else begin
        $error("read data changed under back-pressure");
        fail_cnt++;
    end

    no_self_snoop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ac_valid_i[init_idx_q])
    else begin
        $error("snoop issued to the initiating master");
        fail_cnt++;
    end

    // nothing leaves toward master or memory while snoops are open
    snoop_phase_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (|ac_valid_i || |cr_ready_i) |-> !r_valid_i && !mem_ar_valid_i)
    else begin
        $error("read data or memory request during snoop phase");
        fail_cnt++;
    end

    r_vs_mem_ar: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_i |-> !mem_ar_valid_i)
    else begin
        $error("read data and memory request at the same time");
        fail_cnt++;
    end

endmodule

bind ccu_top ccu_asserts i_asserts (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_i     (ar_ready_o),
    .ar_id_i        (ar_id_i),
    .r_valid_i      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .r_data_i       (r_data_o),
    .r_last_i       (r_last_o),
    .r_shared_i     (r_shared_o),
    .r_dirty_i      (r_dirty_o),
    .mem_ar_valid_i (mem_ar_valid_o),
    .ac_valid_i     (ac_valid_o),
    .cr_ready_i     (cr_ready_o)
);

/* testbench/ccu_tb.sv */
`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_tb
    import ccu_pkg::*;
();

    localparam int num_rand   = 40;
    // requests: miss, hit, multi hit, one per initiator, random
    localparam int num_reqs   = 7 + num_rand;
    localparam int req_cycles = 200;

    logic     clk_i;
    logic     rst_ni;
    logic     ar_valid_i, ar_ready_o;
    addr_t    ar_addr_i;
    id_t      ar_id_i;
    snoop_t   ar_snoop_i;
    logic     r_valid_o, r_ready_i, r_last_o, r_shared_o, r_dirty_o;
    data_t    r_data_o;
    id_t      r_id_o;
    logic     mem_ar_valid_o, mem_ar_ready_i;
    addr_t    mem_ar_addr_o;
    id_t      mem_ar_id_o;
    logic     mem_r_valid_i, mem_r_ready_o, mem_r_last_i;
    data_t    mem_r_data_i;
    mst_vec_t ac_valid_o, ac_ready_i, cr_valid_i, cr_ready_o;
    mst_vec_t cr_data_transfer_i, cr_error_i, cr_shared_i, cr_dirty_i;
    mst_vec_t cd_valid_i, cd_ready_o, cd_last_i;
    addr_t    ac_addr_o;
    snoop_t   ac_snoop_o;
    data_t [`CCU_NUM_MASTERS-1:0] cd_data_i;

    // current request, flags already masked to the snooped masters
    mst_vec_t cfg_dt, cfg_err, cfg_sh, cfg_dy;
    addr_t    cur_addr;
    id_t      cur_id;
    snoop_t   cur_snoop;
    logic     bp_en;

    // snoop master and memory model state
    mst_vec_t ac_seen, cr_sent, ac_mask;
    addr_t    snp_addr [`CCU_NUM_MASTERS];
    int       cd_cnt [`CCU_NUM_MASTERS];
    addr_t    mem_addr;
    logic     mem_pending;
    int       mem_beat, mem_ar_cnt, r_cnt;
    int       err_cnt, test_cnt, test_fail;

    ccu_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    // --------------------------------------------------
    // data patterns and reference model
    // --------------------------------------------------
    function automatic data_t snoop_beat(input int m, input addr_t a, input int k);
        return {a, 24'hc0_ffee, 4'(m), 4'(k)};
    endfunction

    function automatic data_t mem_beat_data(input addr_t a, input int k);
        return {~a, 24'h3e_3e3e, 4'hf, 4'(k)};
    endfunction

    // two 8-byte beats per line, so 16-byte alignment
    function automatic addr_t line_of(input addr_t a);
        return {a[`CCU_ADDR_W-1:4], 4'h0};
    endfunction

    // lowest error-free data holder, -1 means memory
    function automatic int exp_responder();
        int r;
        r = -1;
        for (int m = `CCU_NUM_MASTERS - 1; m >= 0; m--) begin
            if (cfg_dt[m] && !cfg_err[m]) begin
                r = m;
            end
        end
        return r;
    endfunction

    // {data, last, shared, dirty} of read beat k
    function automatic logic [`CCU_DATA_W+2:0] expected_beat(input int k);
        int    r;
        data_t d;
        logic  sh;
        logic  dy;
        r = exp_responder();
        if (r >= 0) begin
            d  = snoop_beat(r, line_of(cur_addr), k);
            sh = |cfg_sh;
            dy = |cfg_dy;
        end else begin
            d  = mem_beat_data(line_of(cur_addr), k);
            sh = 1'b0;
            dy = 1'b0;
        end
        return {d, (k == `CCU_LINE_BEATS - 1), sh, dy};
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            err_cnt++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt != errs_before) begin
            test_fail++;
            $display("test %0d %s: failed", test_cnt, name);
        end else begin
            $display("test %0d %s: ok", test_cnt, name);
        end
    endtask

    // --------------------------------------------------
    // bus models, driven on the falling edge
    // --------------------------------------------------
    always begin
        @(negedge clk_i);
        for (int m = 0; m < `CCU_NUM_MASTERS; m++) begin
            ac_ready_i[m] = ($urandom_range(3) != 0);
            cr_valid_i[m] = ac_seen[m] && !cr_sent[m];
            cd_valid_i[m] = cr_sent[m] && cfg_dt[m] && (cd_cnt[m] < `CCU_LINE_BEATS);
            cd_last_i[m]  = (cd_cnt[m] == `CCU_LINE_BEATS - 1);
            cd_data_i[m]  = snoop_beat(m, snp_addr[m], cd_cnt[m]);
        end
        cr_data_transfer_i = cfg_dt;
        cr_error_i         = cfg_err;
        cr_shared_i        = cfg_sh;
        cr_dirty_i         = cfg_dy;
        mem_ar_ready_i     = ($urandom_range(1) != 0);
        mem_r_valid_i      = mem_pending && (mem_beat < `CCU_LINE_BEATS);
        mem_r_last_i       = (mem_beat == `CCU_LINE_BEATS - 1);
        mem_r_data_i       = mem_beat_data(mem_addr, mem_beat);
        r_ready_i          = !bp_en || ($urandom_range(2) == 0);
        // handshakes sampled just before the rising edge
        #4;
        for (int m = 0; m < `CCU_NUM_MASTERS; m++) begin
            if (ac_valid_o[m] && ac_ready_i[m]) begin
                ac_seen[m]  = 1'b1;
                snp_addr[m] = ac_addr_o;
                check("ac_addr_o", 64'(ac_addr_o), 64'(line_of(cur_addr)));
                check("ac_snoop_o", 64'(ac_snoop_o), 64'(cur_snoop));
            end
            if (cr_valid_i[m] && cr_ready_o[m]) begin
                cr_sent[m] = 1'b1;
            end
            if (cd_valid_i[m] && cd_ready_o[m]) begin
                cd_cnt[m]++;
            end
        end
        ac_mask = ac_mask | ac_valid_o;
        if (mem_ar_valid_o && mem_ar_ready_i) begin
            mem_ar_cnt++;
            mem_addr    = mem_ar_addr_o;
            mem_pending = 1'b1;
            check("mem_ar_addr_o", 64'(mem_ar_addr_o), 64'(line_of(cur_addr)));
            check("mem_ar_id_o", 64'(mem_ar_id_o), 64'(cur_id));
        end
        if (mem_r_valid_i && mem_r_ready_o) begin
            mem_beat++;
        end
    end

    // read data monitor
    always begin
        logic [`CCU_DATA_W+2:0] want;
        @(negedge clk_i);
        #4;
        if (r_valid_o && r_ready_i) begin
            want = expected_beat(r_cnt);
            check("r_data_o", r_data_o, want[`CCU_DATA_W+2:3]);
            check("r_last_o", 64'(r_last_o), 64'(want[2]));
            check("r_shared_o", 64'(r_shared_o), 64'(want[1]));
            check("r_dirty_o", 64'(r_dirty_o), 64'(want[0]));
            check("r_id_o", 64'(r_id_o), 64'(cur_id));
            r_cnt++;
        end
    end

    // one line read from master mst, returns after the last read beat
    task automatic run_req(input int mst, input mst_vec_t dt, input mst_vec_t err,
                           input mst_vec_t sh, input mst_vec_t dy);
        mst_vec_t                  init;
        mst_vec_t                  others;
        logic [`CCU_SLV_ID_W-1:0] slv;
        int                        resp;
        init      = mst_vec_t'(1) << mst;
        others    = ~init;
        cfg_dt    = dt & others;
        cfg_err   = err & others;
        cfg_sh    = sh & others;
        cfg_dy    = dy & others;
        slv       = `CCU_SLV_ID_W'($urandom_range(3));
        cur_addr  = $urandom();
        cur_id    = {mst_idx_t'(mst), slv};
        cur_snoop = snoop_t'($urandom_range(15));
        ac_seen   = '0;
        cr_sent   = '0;
        ac_mask   = '0;
        for (int m = 0; m < `CCU_NUM_MASTERS; m++) begin
            cd_cnt[m] = 0;
        end
        mem_pending = 1'b0;
        mem_beat    = 0;
        mem_ar_cnt  = 0;
        r_cnt       = 0;
        @(negedge clk_i);
        ar_valid_i = 1'b1;
        ar_addr_i  = cur_addr;
        ar_id_i    = cur_id;
        ar_snoop_i = cur_snoop;
        #4;
        while (!ar_ready_o) begin
            @(negedge clk_i);
            #4;
        end
        @(negedge clk_i);
        ar_valid_i = 1'b0;
        while (r_cnt < `CCU_LINE_BEATS) begin
            @(posedge clk_i);
        end
        resp = exp_responder();
        check("ac_valid_o", 64'(ac_mask), 64'(others));
        check("mem_ar count", 64'(mem_ar_cnt), (resp >= 0) ? 64'd0 : 64'd1);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int e;
        void'($urandom(32'hea7f_8f88));
        rst_ni = 1'b0;
        ar_valid_i = 1'b0;
        ar_addr_i = '0;
        ar_id_i = '0;
        ar_snoop_i = '0;
        r_ready_i = 1'b0;
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i = 1'b0;
        mem_r_data_i = '0;
        mem_r_last_i = 1'b0;
        ac_ready_i = '0;
        cr_valid_i = '0;
        cr_data_transfer_i = '0;
        cr_error_i = '0;
        cr_shared_i = '0;
        cr_dirty_i = '0;
        cd_valid_i = '0;
        cd_data_i = '0;
        cd_last_i = '0;
        cfg_dt = '0;
        cfg_err = '0;
        cfg_sh = '0;
        cfg_dy = '0;
        cur_addr = '0;
        cur_id = '0;
        cur_snoop = '0;
        bp_en = 1'b0;
        ac_seen = '0;
        cr_sent = '0;
        ac_mask = '0;
        for (int m = 0; m < `CCU_NUM_MASTERS; m++) begin
            snp_addr[m] = '0;
            cd_cnt[m] = 0;
        end
        mem_addr = '0;
        mem_pending = 1'b0;
        mem_beat = 0;
        mem_ar_cnt = 0;
        r_cnt = 0;
        err_cnt = 0;
        test_cnt = 0;
        test_fail = 0;
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;

        e = err_cnt;
        @(negedge clk_i);
        #4;
        check("ar_ready_o", 64'(ar_ready_o), 64'd1);
        check("r_valid_o", 64'(r_valid_o), 64'd0);
        check("ac_valid_o", 64'(ac_valid_o), 64'd0);
        check("cr_ready_o", 64'(cr_ready_o), 64'd0);
        check("cd_ready_o", 64'(cd_ready_o), 64'd0);
        check("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd0);
        check("mem_r_ready_o", 64'(mem_r_ready_o), 64'd0);
        report("reset state", e);

        e = err_cnt;
        run_req(0, 4'b0000, 4'b0000, 4'b0100, 4'b0000);
        report("snoop miss reads memory", e);

        e = err_cnt;
        run_req(1, 4'b0100, 4'b0000, 4'b0000, 4'b0100);
        report("single snoop hit", e);

        // master 0 has data with error, master 1 wins
        e = err_cnt;
        run_req(3, 4'b0111, 4'b0001, 4'b0100, 4'b0001);
        report("lowest error-free responder", e);

        e = err_cnt;
        for (int m = 0; m < `CCU_NUM_MASTERS; m++) begin
            run_req(m, mst_vec_t'($urandom_range(15)), mst_vec_t'($urandom_range(15)),
                    mst_vec_t'($urandom_range(15)), mst_vec_t'($urandom_range(15)));
        end
        report("initiator never snooped", e);

        e = err_cnt;
        bp_en = 1'b1;
        repeat (num_rand) begin
            run_req($urandom_range(3), mst_vec_t'($urandom_range(15)),
                    mst_vec_t'($urandom_range(15)), mst_vec_t'($urandom_range(15)),
                    mst_vec_t'($urandom_range(15)));
        end
        report("random back-pressure", e);

        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 test_cnt, test_fail, err_cnt, UUT.i_asserts.fail_cnt);
        if (err_cnt == 0 && UUT.i_asserts.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog, bound per request plus reset
    initial begin
        #((num_reqs + 2) * req_cycles * 10);
        $display("run did not finish within %0d cycles", (num_reqs + 2) * req_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/ccu_pkg.sv
hw/ccu_req_capture.sv
hw/ccu_snoop_collect.sv
hw/ccu_ctrl_fsm.sv
hw/ccu_read_return.sv
hw/ccu_top.sv
testbench/ccu_asserts.sv
testbench/ccu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ccu_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_FLAGS ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
